// File: counter_lab.f
src/counter_lab_pkg.sv
src/count_if.sv
src/input_conditioner.sv
src/strobe_gen.sv
src/counter_bank.sv
src/seven_segment_display.sv
src/display_driver.sv
src/counter_lab.sv
verif/tb_counter_lab.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --timescale 1ns/1ps -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps -Wall -Wno-fatal
TOP        = tb_counter_lab
RTL_TOP    = counter_lab
FILELIST   = counter_lab.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/counter_lab_stim.txt
# W sw(hex) key(hex) cycles | L expected led(hex) | M led against the model
# D cycles of display scan checks against the model, switches held
W 02 0 6
L 00
W 02 1 4
W 02 0 4
L 01
W 02 1 4
W 02 0 4
L 02
W 02 1 4
W 02 0 4
L 03
D 32
W 03 0 4
L 00
W 03 1 4
W 03 0 4
L 00
W 04 0 3
M
W 06 0 3
M
W 08 0 3
M
W 0A 0 20
M
W 0C 0 25
M
W 08 0 5000
M
W 00 0 4
M
D 40
W 0E 0 3
M

// File: verif/tb_counter_lab.sv
`timescale 1ns/1ps
`default_nettype none

module tb_counter_lab;

    import counter_lab_pkg::*;

    // DUT configuration with a strobe period of 10 cycles
    localparam int clk_mhz       = 1;
    localparam int strobe_hz     = 100000;
    localparam int w_prescale    = 3;
    localparam int w_refresh     = 2;
    localparam int strobe_period = clk_mhz * 1_000_000 / strobe_hz;
    localparam int reset_cycles  = 10;
    localparam int margin_cycles = 100;

    logic               clk;
    logic               rst;
    logic [w_key-1:0]   key;
    logic [w_sw-1:0]    sw;
    logic [w_led-1:0]   led;
    seg_t               abcdefgh;
    logic [w_digit-1:0] digit;

    // Parsed stimulus lines
    byte ops[$];
    int  arg_a[$];
    int  arg_b[$];
    int  arg_c[$];

    int                 cycle_limit = 0;
    int                 cycle_count = 0;
    // Edges since reset release for the model
    int                 edges = 0;
    logic [w_sw-1:0]    sw_hist [4];
    logic [w_led-1:0]   step_expect;

    counter_lab
    #(
        .clk_mhz    (clk_mhz),
        .strobe_hz  (strobe_hz),
        .w_prescale (w_prescale),
        .w_refresh  (w_refresh)
    )
    u_dut
    (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #4 clk = ~clk;

    //------------------------------------------------------------------------
    // Reference model and run limit
    //------------------------------------------------------------------------

    // Switch sample history
    // Index 2 sets the view now and index 3 set it one edge ago
    always @(posedge clk)
    begin
        if (rst)
        begin
            edges      <= 0;
            sw_hist[0] <= '0;
            sw_hist[1] <= '0;
            sw_hist[2] <= '0;
            sw_hist[3] <= '0;
        end
        else
        begin
            edges      <= edges + 1;
            sw_hist[0] <= sw;
            sw_hist[1] <= sw_hist[0];
            sw_hist[2] <= sw_hist[1];
            sw_hist[3] <= sw_hist[2];
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
            stop_on_failure($sformatf("Timeout: the run did not end within %0d cycles",
                                      cycle_limit));
    end

    // LED value for a switch setting after n edges
    function automatic logic [w_led-1:0] led_model(input logic [w_sw-1:0] sw_v, input int n,
                                                   input logic [w_led-1:0] step);
        logic [w_free-1:0] free;
        free = n;
        case (view_sel_t'(sw_v[3:1]))
            view_step:      return step;
            view_tap_mid:   return free[tap_mid_msb -: w_led];
            view_tap_low:   return free[tap_low_msb -: w_led];
            // One count per 2^w_prescale edges
            view_prescaled: return w_led'(n >> w_prescale);
            // One count per strobe period
            view_strobe:    return w_led'(n / strobe_period);
            default:        return free[tap_hi_msb -: w_led];
        endcase
    endfunction

    // Displayed number is the full free count when every switch is low
    function automatic logic [w_number-1:0] number_model(input logic [w_sw-1:0] sw_v,
                                                         input int n,
                                                         input logic [w_led-1:0] step);
        if (sw_v == '0)
            return w_number'(n);
        else
            return w_number'(led_model(sw_v, n, step));
    endfunction

    //------------------------------------------------------------------------
    // Checks
    //------------------------------------------------------------------------

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_led(input logic [w_led-1:0] expected, input logic [w_led-1:0] actual);
        if (actual !== expected)
            stop_on_failure($sformatf("FAIL time=%0t signal=led expected=0x%02h actual=0x%02h",
                                      $time, expected, actual));
    endtask

    task automatic check_segments(input seg_t expected, input seg_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("FAIL time=%0t signal=abcdefgh expected=%08b actual=%08b",
                                      $time, expected, actual));
    endtask

    task automatic check_digit(input logic [w_digit-1:0] expected,
                               input logic [w_digit-1:0] actual);
        if (actual !== expected)
            stop_on_failure($sformatf("FAIL time=%0t signal=digit expected=%08b actual=%08b",
                                      $time, expected, actual));
    endtask

    // Display outputs show the number as it stood one edge earlier
    task automatic check_display(input int n);
        int                  idx;
        logic [w_number-1:0] number;
        logic [w_digit-1:0]  exp_digit;
        seg_t                exp_seg;
        idx       = ((n - 1) >> w_refresh) % w_digit;
        exp_digit = w_digit'(1) << idx;
        number    = number_model(sw_hist[3], n - 1, step_expect);
        exp_seg   = hex_to_segments(number[idx * w_nibble +: w_nibble]);
        // Dot always dark
        exp_seg[0] = 1'b0;
        if (!$onehot(digit))
            stop_on_failure($sformatf("Digit enable is not one-hot at time %0t", $time));
        check_digit(exp_digit, digit);
        check_segments(exp_seg, abcdefgh);
    endtask

    //------------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------------

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_stimulus(output int wait_sum);
        int    fd;
        int    fields;
        int    a;
        int    b;
        int    c;
        byte   op;
        string line;
        string rest;
        wait_sum = 0;
        fd = $fopen("verif/counter_lab_stim.txt", "r");
        if (fd == 0)
            stop_on_failure("Could not open the stimulus file verif/counter_lab_stim.txt");
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                op   = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                a    = 0;
                b    = 0;
                c    = 0;
                case (op)
                    "W":
                    begin
                        fields = $sscanf(rest, "%h %h %d", a, b, c);
                        if (fields != 3)
                            stop_on_failure({"Malformed wait line in stimulus: ", line});
                        wait_sum += c;
                    end
                    "D":
                    begin
                        fields = $sscanf(rest, "%d", c);
                        if (fields != 1)
                            stop_on_failure({"Malformed display line in stimulus: ", line});
                        wait_sum += c;
                    end
                    "L":
                    begin
                        fields = $sscanf(rest, "%h", a);
                        if (fields != 1)
                            stop_on_failure({"Malformed LED line in stimulus: ", line});
                    end
                    "M":
                        fields = 0;
                    default:
                        stop_on_failure({"Unknown line in stimulus: ", line});
                endcase
                ops.push_back(op);
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_stimulus();
        int i;
        for (i = 0; i < ops.size(); i++)
        begin
            case (ops[i])
                "W":
                begin
                    sw  = w_sw'(arg_a[i]);
                    key = w_key'(arg_b[i]);
                    repeat (arg_c[i])
                        next_cycle();
                end
                "D":
                begin
                    // Expected index steps through every digit over a full scan
                    repeat (arg_c[i])
                    begin
                        next_cycle();
                        check_display(edges);
                    end
                end
                "L":
                begin
                    check_led(w_led'(arg_a[i]), led);
                    // Step count known from the file from here on
                    if (view_sel_t'(sw_hist[2][3:1]) == view_step)
                        step_expect = w_led'(arg_a[i]);
                end
                default:
                    check_led(led_model(sw_hist[2], edges, step_expect), led);
            endcase
        end
    endtask

    initial
    begin
        int wait_sum;
        clk         = 1'b0;
        rst         = 1'b1;
        key         = '0;
        sw          = '0;
        step_expect = '0;
        load_stimulus(wait_sum);
        cycle_limit = wait_sum + reset_cycles + margin_cycles;

        repeat (reset_cycles)
            @(posedge clk);
        #1;
        // Reset state of the outputs
        check_digit(w_digit'(1), digit);
        check_segments('0, abcdefgh);
        check_led('0, led);
        rst = 1'b0;

        run_stimulus();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/counter_lab.sv
`timescale 1ns/1ps
`default_nettype none

module counter_lab
#(
    parameter int clk_mhz    = 50,
    parameter int strobe_hz  = 5,
    parameter int w_prescale = 20,
    parameter int w_refresh  = 16
)
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [counter_lab_pkg::w_key-1:0]   key,
    input  logic [counter_lab_pkg::w_sw-1:0]    sw,
    output logic [counter_lab_pkg::w_led-1:0]   led,
    output counter_lab_pkg::seg_t               abcdefgh,
    output logic [counter_lab_pkg::w_digit-1:0] digit
);

    import counter_lab_pkg::*;

    // Conditioned controls
    view_sel_t view_sel;
    logic      all_clear_view;
    logic      step_clear;
    logic      step_pulse;

    // Counter values to the display side
    count_if counts ();

    //------------------------------------------------------------------------
    // Input, counters, output
    //------------------------------------------------------------------------

    input_conditioner u_input_conditioner
    (
        .clk            (clk),
        .rst            (rst),
        .key            (key),
        .sw             (sw),
        .view_sel       (view_sel),
        .all_clear_view (all_clear_view),
        .step_clear     (step_clear),
        .step_pulse     (step_pulse)
    );

    counter_bank
    #(
        .clk_mhz    (clk_mhz),
        .strobe_hz  (strobe_hz),
        .w_prescale (w_prescale)
    )
    u_counter_bank
    (
        .clk        (clk),
        .rst        (rst),
        .step_clear (step_clear),
        .step_pulse (step_pulse),
        .counts     (counts.producer)
    );

    display_driver
    #(
        .w_refresh (w_refresh)
    )
    u_display_driver
    (
        .clk            (clk),
        .rst            (rst),
        .counts         (counts.consumer),
        .view_sel       (view_sel),
        .all_clear_view (all_clear_view),
        .led            (led),
        .abcdefgh       (abcdefgh),
        .digit          (digit)
    );

endmodule

`default_nettype wire

// File: src/display_driver.sv
`timescale 1ns/1ps
`default_nettype none

module display_driver
#(
    parameter int w_refresh = 16
)
(
    input  logic                                clk,
    input  logic                                rst,
    count_if.consumer                           counts,
    input  counter_lab_pkg::view_sel_t          view_sel,
    input  logic                                all_clear_view,
    output logic [counter_lab_pkg::w_led-1:0]   led,
    output counter_lab_pkg::seg_t               abcdefgh,
    output logic [counter_lab_pkg::w_digit-1:0] digit
);

    import counter_lab_pkg::*;

    logic [w_led-1:0]    led_view;
    logic [w_number-1:0] number;

    //------------------------------------------------------------------------
    // LED view select
    //------------------------------------------------------------------------

    always_comb
    begin
        case (view_sel)
            view_step:      led_view = counts.step_count;
            view_tap_hi:    led_view = counts.free_count[tap_hi_msb -: w_led];
            view_tap_mid:   led_view = counts.free_count[tap_mid_msb -: w_led];
            view_tap_low:   led_view = counts.free_count[tap_low_msb -: w_led];
            view_prescaled: led_view = counts.prescaled_count;
            view_strobe:    led_view = counts.strobe_count;
            // Default and alt default both show the high tap
            default:        led_view = counts.free_count[tap_hi_msb -: w_led];
        endcase
    end

    assign led = led_view;

    // Full free count when every switch is low, else the LED value
    assign number = all_clear_view ? w_number'(counts.free_count)
                                   : w_number'(led_view);

    //------------------------------------------------------------------------
    // Scanned display
    //------------------------------------------------------------------------

    seven_segment_display
    #(
        .w_refresh (w_refresh)
    )
    u_seven_segment_display
    (
        .clk      (clk),
        .rst      (rst),
        .number   (number),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

// File: src/seven_segment_display.sv
`timescale 1ns/1ps
`default_nettype none

module seven_segment_display
#(
    parameter int w_refresh = 16
)
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [counter_lab_pkg::w_number-1:0]  number,
    output counter_lab_pkg::seg_t                 abcdefgh,
    output logic [counter_lab_pkg::w_digit-1:0]   digit
);

    import counter_lab_pkg::*;

    logic [w_refresh-1:0]   refresh_cnt;
    logic                   refresh_tick;
    logic [w_digit_idx-1:0] digit_idx;
    // Nibble of the current digit and its font
    logic [w_nibble-1:0]    nibble;
    seg_t                   nibble_seg;

    //------------------------------------------------------------------------
    // Refresh timing
    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    // Last cycle of each refresh slot
    assign refresh_tick = &refresh_cnt;

    // Digit index wraps after the last digit
    always_ff @(posedge clk)
    begin
        if (rst)
            digit_idx <= '0;
        else if (refresh_tick)
        begin
            if (digit_idx == w_digit_idx'(w_digit - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Hex decode and output registers
    //------------------------------------------------------------------------

    assign nibble     = number[digit_idx * w_nibble +: w_nibble];
    assign nibble_seg = hex_to_segments(nibble);

    // Segments and enable share one register stage
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            abcdefgh <= '0;
            digit    <= w_digit'(1);
        end
        else
        begin
            // Dot forced off
            abcdefgh <= {nibble_seg[7:1], 1'b0};
            digit    <= w_digit'(1) << digit_idx;
        end
    end

endmodule

`default_nettype wire

// File: src/counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module counter_bank
#(
    parameter int clk_mhz    = 50,
    parameter int strobe_hz  = 5,
    parameter int w_prescale = 20
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      step_clear,
    input  logic      step_pulse,
    count_if.producer counts
);

    import counter_lab_pkg::*;

    // Enables for the prescaled and strobe counters
    logic prescale_en;
    logic strobe;

    //------------------------------------------------------------------------
    // Free-running counter
    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            counts.free_count <= '0;
        else
            counts.free_count <= counts.free_count + 1'b1;
    end

    // Once every 2^w_prescale cycles
    assign prescale_en = &counts.free_count[w_prescale-1:0];

    //------------------------------------------------------------------------
    // Prescaled counter
    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            counts.prescaled_count <= '0;
        else if (prescale_en)
            counts.prescaled_count <= counts.prescaled_count + 1'b1;
    end

    //------------------------------------------------------------------------
    // Strobe counter
    //------------------------------------------------------------------------

    strobe_gen
    #(
        .clk_mhz   (clk_mhz),
        .strobe_hz (strobe_hz)
    )
    u_strobe_gen
    (
        .clk    (clk),
        .rst    (rst),
        .strobe (strobe)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
            counts.strobe_count <= '0;
        else if (strobe)
            counts.strobe_count <= counts.strobe_count + 1'b1;
    end

    //------------------------------------------------------------------------
    // Step counter
    //------------------------------------------------------------------------

    // Clear has priority over a step
    always_ff @(posedge clk)
    begin
        if (rst || step_clear)
            counts.step_count <= '0;
        else if (step_pulse)
            counts.step_count <= counts.step_count + 1'b1;
    end

endmodule

`default_nettype wire

// File: src/strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module strobe_gen
#(
    parameter int clk_mhz   = 50,
    parameter int strobe_hz = 5
)
(
    input  logic clk,
    input  logic rst,
    output logic strobe
);

    // Clock cycles per strobe
    localparam int period = clk_mhz * 1_000_000 / strobe_hz;
    localparam int w_cnt  = $clog2(period + 1);

    logic [w_cnt-1:0] cnt;

    //------------------------------------------------------------------------
    // Down-counter, reloads at zero
    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            cnt <= w_cnt'(period - 1);
        else if (cnt == '0)
            cnt <= w_cnt'(period - 1);
        else
            cnt <= cnt - 1'b1;
    end

    // High for the one cycle spent at zero
    assign strobe = (cnt == '0);

endmodule

`default_nettype wire

// File: src/input_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module input_conditioner
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic [counter_lab_pkg::w_key-1:0]   key,
    input  logic [counter_lab_pkg::w_sw-1:0]    sw,
    output counter_lab_pkg::view_sel_t          view_sel,
    output logic                                all_clear_view,
    output logic                                step_clear,
    output logic                                step_pulse
);

    import counter_lab_pkg::*;

    //------------------------------------------------------------------------
    // Two-flop synchronizers
    //------------------------------------------------------------------------

    // Only key[0] has a function
    logic             key_meta;
    logic             key_sync;
    logic [w_sw-1:0]  sw_meta;
    logic [w_sw-1:0]  sw_sync;
    // Previous synchronized key[0] for edge detect
    logic             key0_prev;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_meta <= 1'b0;
            key_sync <= 1'b0;
            sw_meta  <= '0;
            sw_sync  <= '0;
        end
        else
        begin
            key_meta <= key[0];
            key_sync <= key_meta;
            sw_meta  <= sw;
            sw_sync  <= sw_meta;
        end
    end

    //------------------------------------------------------------------------
    // Decode stage
    //------------------------------------------------------------------------

    // Registered so every output lands two edges after first sampling
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key0_prev      <= 1'b0;
            step_pulse     <= 1'b0;
            step_clear     <= 1'b0;
            all_clear_view <= 1'b0;
            view_sel       <= view_default;
        end
        else
        begin
            key0_prev      <= key_sync;
            // One cycle per rising edge of key[0]
            step_pulse     <= key_sync & ~key0_prev;
            step_clear     <= sw_sync[0];
            all_clear_view <= ~|sw_sync;
            view_sel       <= view_sel_t'(sw_sync[3:1]);
        end
    end

endmodule

`default_nettype wire

// File: src/count_if.sv
`timescale 1ns/1ps
`default_nettype none

interface count_if;

    import counter_lab_pkg::*;

    //------------------------------------------------------------------------
    // Counter values, all registered levels
    //------------------------------------------------------------------------

    // Manual step count
    logic [w_led-1:0]  step_count;
    // Prescaled count
    logic [w_led-1:0]  prescaled_count;
    // Strobe-driven count
    logic [w_led-1:0]  strobe_count;
    // Free-running count, source of the taps
    logic [w_free-1:0] free_count;

    // Counter bank side
    modport producer (
        output step_count,
        output prescaled_count,
        output strobe_count,
        output free_count
    );

    // Display side
    modport consumer (
        input step_count,
        input prescaled_count,
        input strobe_count,
        input free_count
    );

endinterface

`default_nettype wire

// File: src/counter_lab_pkg.sv
`default_nettype none

package counter_lab_pkg;

    // Board I/O widths
    localparam int w_key   = 4;
    localparam int w_sw    = 8;
    localparam int w_led   = 8;
    localparam int w_digit = 8;

    // Counter and display widths
    localparam int w_free      = 32;
    localparam int w_number    = 32;
    localparam int w_nibble    = 4;
    localparam int w_digit_idx = $clog2(w_digit);

    // Top bit of each 8-bit tap of the free count
    localparam int tap_hi_msb  = 31;
    localparam int tap_mid_msb = 23;
    localparam int tap_low_msb = 19;

    // View select from sw[3:1]; 0 and 7 both show the high tap
    typedef enum logic [2:0] {
        view_default     = 3'd0,
        view_step        = 3'd1,
        view_tap_hi      = 3'd2,
        view_tap_mid     = 3'd3,
        view_tap_low     = 3'd4,
        view_prescaled   = 3'd5,
        view_strobe      = 3'd6,
        view_default_alt = 3'd7
    } view_sel_t;

    // Segments a b c d e f g h, bit 7 is a, bit 0 is the decimal point
    typedef logic [7:0] seg_t;

    // Standard hex font, active-high segments, dot off
    function automatic seg_t hex_to_segments(input logic [w_nibble-1:0] nibble);
        case (nibble)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire
